/* source/cfg_pkg.sv */
package cfg_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int AXI_DATA_W = 32;
  localparam int AXI_ADDR_W = 11;

  typedef logic [AXI_DATA_W-1:0] axi_data_t;
  typedef logic [AXI_ADDR_W-1:0] axi_addr_t;
  typedef logic [3:0]            opcode_t;
  typedef logic [3:0]            status_t;
  typedef logic [15:0]           wait_cnt_t;

  // Command queue sizing
  localparam int CMD_FIFO_DEPTH = 16;
  localparam int FIFO_PTR_W     = $clog2(CMD_FIFO_DEPTH);
  // One extra bit so a full queue fits
  typedef logic [$clog2(CMD_FIFO_DEPTH+1)-1:0] fifo_cnt_t;

  // ConfigClk half-period in ACLK cycles
  localparam int CFG_CLK_DIV = 4;
  localparam int DIV_CNT_W   = (CFG_CLK_DIV > 1) ? $clog2(CFG_CLK_DIV) : 1;

  // ----------------------------------------
  // Opcodes and completion codes
  // ----------------------------------------
  localparam opcode_t OP_RESET     = 4'd1;
  localparam opcode_t OP_CONFIGIN  = 4'd2;
  localparam opcode_t OP_WAIT      = 4'd3;
  localparam opcode_t OP_CONFIGOUT = 4'd4;
  localparam opcode_t OP_LOAD      = 4'd5;

  localparam status_t ST_IDLE      = 4'd1;
  localparam status_t ST_RESET     = 4'd2;
  localparam status_t ST_CONFIGIN  = 4'd3;
  localparam status_t ST_WAIT      = 4'd4;
  localparam status_t ST_LOAD      = 4'd5;
  localparam status_t ST_CONFIGOUT = 4'd8;

  // Register map and AXI responses
  localparam axi_addr_t  ADDR_CMD    = 11'h000;
  localparam axi_addr_t  ADDR_STATUS = 11'h004;
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  // Command word as written by software
  typedef struct packed {
    wait_cnt_t  wait_len;
    logic [9:0] reserved;
    logic       config_bit;
    logic       superpix;
    opcode_t    opcode;
  } cfg_cmd_t;

  // Status word as read back by software
  typedef struct packed {
    logic [7:0] done_count;
    logic [7:0] fifo_level;
    logic [6:0] rsvd_hi;
    logic       config_out;
    logic [2:0] rsvd_lo;
    logic       busy;
    status_t    last_status;
  } cfg_status_t;

endpackage

/* source/axil_cfg_regs.sv */
module axil_cfg_regs (
  input  logic                S_AXI_ACLK,
  input  logic                S_AXI_ARESETN,
  // Write address and data
  input  cfg_pkg::axi_addr_t  S_AXI_AWADDR,
  input  logic                S_AXI_AWVALID,
  output logic                S_AXI_AWREADY,
  input  cfg_pkg::axi_data_t  S_AXI_WDATA,
  input  logic                S_AXI_WVALID,
  output logic                S_AXI_WREADY,
  // Write response
  output logic [1:0]          S_AXI_BRESP,
  output logic                S_AXI_BVALID,
  input  logic                S_AXI_BREADY,
  // Read address and data
  input  cfg_pkg::axi_addr_t  S_AXI_ARADDR,
  input  logic                S_AXI_ARVALID,
  output logic                S_AXI_ARREADY,
  output cfg_pkg::axi_data_t  S_AXI_RDATA,
  output logic [1:0]          S_AXI_RRESP,
  output logic                S_AXI_RVALID,
  input  logic                S_AXI_RREADY,
  // Command queue side
  output logic                push,
  output cfg_pkg::cfg_cmd_t   push_cmd,
  input  logic                fifo_full,
  input  cfg_pkg::fifo_cnt_t  fifo_level,
  input  cfg_pkg::cfg_status_t status
);
  import cfg_pkg::*;

  logic        wr_ready;
  logic        wr_hs;
  logic        wr_to_cmd;
  logic        ar_hs;
  logic        rd_busy_next;
  cfg_status_t rd_status;

  // ----------------------------------------
  // Write channel
  // ----------------------------------------
  // AWREADY and WREADY share one register
  assign S_AXI_AWREADY = wr_ready;
  assign S_AXI_WREADY  = wr_ready;

  assign wr_hs     = wr_ready & S_AXI_AWVALID & S_AXI_WVALID;
  assign wr_to_cmd = (S_AXI_AWADDR == ADDR_CMD);

  // Queue only on a command write that finds room
  assign push     = wr_hs & wr_to_cmd & ~fifo_full;
  assign push_cmd = cfg_cmd_t'(S_AXI_WDATA);

  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      wr_ready     <= 1'b0;
      S_AXI_BVALID <= 1'b0;
    end else begin
      // One-cycle ready once both halves are present and no response waits
      wr_ready <= ~wr_ready & S_AXI_AWVALID & S_AXI_WVALID & ~S_AXI_BVALID;
      if (wr_hs) begin
        S_AXI_BVALID <= 1'b1;
      end else if (S_AXI_BREADY) begin
        S_AXI_BVALID <= 1'b0;
      end
    end
  end

  // Response code captured with the handshake
  always_ff @(posedge S_AXI_ACLK) begin
    if (wr_hs) begin
      S_AXI_BRESP <= push ? RESP_OKAY : RESP_SLVERR;
    end
  end

  // ----------------------------------------
  // Read channel
  // ----------------------------------------
  assign ar_hs = S_AXI_ARREADY & S_AXI_ARVALID;

  // Response pending in the next cycle
  assign rd_busy_next = ar_hs | (S_AXI_RVALID & ~S_AXI_RREADY);

  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      S_AXI_ARREADY <= 1'b0;
      S_AXI_RVALID  <= 1'b0;
    end else begin
      S_AXI_RVALID  <= rd_busy_next;
      S_AXI_ARREADY <= ~rd_busy_next;
    end
  end

  // Sequencer status with the live queue level merged in
  always_comb begin
    rd_status            = status;
    rd_status.fifo_level = 8'(fifo_level);
  end

  always_ff @(posedge S_AXI_ACLK) begin
    if (ar_hs) begin
      if (S_AXI_ARADDR == ADDR_STATUS) begin
        S_AXI_RDATA <= rd_status;
        S_AXI_RRESP <= RESP_OKAY;
      end else begin
        // Unmapped address
        S_AXI_RDATA <= '0;
        S_AXI_RRESP <= RESP_SLVERR;
      end
    end
  end

endmodule

/* source/cmd_fifo.sv */
module cmd_fifo (
  input  logic               S_AXI_ACLK,
  input  logic               S_AXI_ARESETN,
  input  logic               push,
  input  cfg_pkg::cfg_cmd_t  push_cmd,
  input  logic               pop,
  output cfg_pkg::cfg_cmd_t  head_cmd,
  output logic               empty,
  output logic               full,
  output cfg_pkg::fifo_cnt_t level
);
  import cfg_pkg::*;

  cfg_cmd_t               mem [CMD_FIFO_DEPTH];
  logic [FIFO_PTR_W-1:0]  wr_ptr;
  logic [FIFO_PTR_W-1:0]  rd_ptr;
  fifo_cnt_t              count;

  // Pointer advance with wrap at the last slot
  function automatic logic [FIFO_PTR_W-1:0] next_ptr(input logic [FIFO_PTR_W-1:0] ptr);
    if (ptr == FIFO_PTR_W'(CMD_FIFO_DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  // Storage
  always_ff @(posedge S_AXI_ACLK) begin
    if (push) begin
      mem[wr_ptr] <= push_cmd;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= next_ptr(wr_ptr);
      if (pop)  rd_ptr <= next_ptr(rd_ptr);
      // Simultaneous push and pop keep the count
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // Head entry visible without a read strobe
  assign head_cmd = mem[rd_ptr];
  assign empty    = (count == '0);
  assign full     = (count == fifo_cnt_t'(CMD_FIFO_DEPTH));
  assign level    = count;

endmodule

/* source/cfg_clk_gen.sv */
module cfg_clk_gen (
  input  logic S_AXI_ACLK,
  input  logic S_AXI_ARESETN,
  output logic config_clk,
  output logic fall_tick,
  output logic rise_tick
);
  import cfg_pkg::*;

  logic [DIV_CNT_W-1:0] div_cnt;
  logic                 edge_now;

  // Last cycle of a half-period
  assign edge_now = (div_cnt == DIV_CNT_W'(CFG_CLK_DIV - 1));

  // ----------------------------------------
  // Divider
  // ----------------------------------------
  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      div_cnt    <= '0;
      config_clk <= 1'b0;
    end else if (edge_now) begin
      div_cnt    <= '0;
      config_clk <= ~config_clk;
    end else begin
      div_cnt <= div_cnt + 1'b1;
    end
  end

  // Edge flags, valid in the cycle whose closing ACLK edge toggles config_clk
  // Logic registered on that edge changes together with the pin
  assign fall_tick = edge_now & config_clk;
  assign rise_tick = edge_now & ~config_clk;

endmodule

/* source/cfg_sequencer.sv */
module cfg_sequencer (
  input  logic                 S_AXI_ACLK,
  input  logic                 S_AXI_ARESETN,
  input  logic                 fall_tick,
  input  logic                 rise_tick,
  input  cfg_pkg::cfg_cmd_t    head_cmd,
  input  logic                 empty,
  input  logic                 config_out,
  output logic                 pop,
  output logic                 superpix_sel,
  output logic                 reset_n_pin,
  output logic                 config_in,
  output logic                 config_load,
  output cfg_pkg::cfg_status_t status
);
  import cfg_pkg::*;

  typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_RESET,
    SEQ_CONFIGIN,
    SEQ_LOAD,
    SEQ_WAIT,
    SEQ_CONFIGOUT
  } seq_state_t;

  seq_state_t state;
  wait_cnt_t  wait_cnt;
  logic       start;
  logic       done;
  status_t    done_st;
  // Status fields
  logic [7:0] done_count;
  status_t    last_status;
  logic       busy;
  logic       cout_q;

  // Take the head entry on a falling ConfigClk
  assign start = (state == SEQ_IDLE) && fall_tick && !empty;
  assign pop   = start;

  // ----------------------------------------
  // Completion detect
  // ----------------------------------------
  always_comb begin
    done    = 1'b0;
    done_st = ST_IDLE;
    case (state)
      SEQ_IDLE: begin
        // Unknown opcode finishes on the start tick
        if (start) begin
          case (head_cmd.opcode)
            OP_RESET, OP_CONFIGIN, OP_WAIT, OP_CONFIGOUT, OP_LOAD: done = 1'b0;
            default: done = 1'b1;
          endcase
        end
      end
      SEQ_RESET: begin
        done    = fall_tick;
        done_st = ST_RESET;
      end
      SEQ_CONFIGIN: begin
        done    = fall_tick;
        done_st = ST_CONFIGIN;
      end
      SEQ_LOAD: begin
        done    = fall_tick;
        done_st = ST_LOAD;
      end
      SEQ_WAIT: begin
        // Zero length behaves as one period
        done    = fall_tick && (wait_cnt <= wait_cnt_t'(1));
        done_st = ST_WAIT;
      end
      SEQ_CONFIGOUT: begin
        done    = rise_tick;
        done_st = ST_CONFIGOUT;
      end
      default: done = 1'b0;
    endcase
  end

  // ----------------------------------------
  // FSM and chip pins
  // ----------------------------------------
  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      state        <= SEQ_IDLE;
      wait_cnt     <= '0;
      superpix_sel <= 1'b0;
      reset_n_pin  <= 1'b1;
      config_in    <= 1'b0;
      config_load  <= 1'b0;
    end else begin
      case (state)
        SEQ_IDLE: begin
          if (start) begin
            case (head_cmd.opcode)
              OP_RESET: begin
                superpix_sel <= head_cmd.superpix;
                reset_n_pin  <= 1'b0;
                state        <= SEQ_RESET;
              end
              OP_CONFIGIN: begin
                config_in <= head_cmd.config_bit;
                state     <= SEQ_CONFIGIN;
              end
              OP_LOAD: begin
                config_load <= 1'b1;
                state       <= SEQ_LOAD;
              end
              OP_WAIT: begin
                wait_cnt <= head_cmd.wait_len;
                state    <= SEQ_WAIT;
              end
              OP_CONFIGOUT: state <= SEQ_CONFIGOUT;
              default:      state <= SEQ_IDLE;
            endcase
          end
        end
        // Pulses end one ConfigClk period after they began
        SEQ_RESET: begin
          if (fall_tick) begin
            reset_n_pin <= 1'b1;
            state       <= SEQ_IDLE;
          end
        end
        SEQ_CONFIGIN: begin
          if (fall_tick) begin
            config_in <= 1'b0;
            state     <= SEQ_IDLE;
          end
        end
        SEQ_LOAD: begin
          if (fall_tick) begin
            config_load <= 1'b0;
            state       <= SEQ_IDLE;
          end
        end
        SEQ_WAIT: begin
          if (done) begin
            state <= SEQ_IDLE;
          end else if (fall_tick) begin
            wait_cnt <= wait_cnt - 1'b1;
          end
        end
        SEQ_CONFIGOUT: begin
          if (rise_tick) state <= SEQ_IDLE;
        end
        default: state <= SEQ_IDLE;
      endcase
    end
  end

  // ----------------------------------------
  // Status record
  // ----------------------------------------
  always_ff @(posedge S_AXI_ACLK or negedge S_AXI_ARESETN) begin
    if (!S_AXI_ARESETN) begin
      done_count  <= '0;
      last_status <= '0;
      busy        <= 1'b0;
      cout_q      <= 1'b0;
    end else begin
      if (start) busy <= 1'b1;
      // Completion wins over start for an unknown opcode
      if (done) begin
        busy        <= 1'b0;
        last_status <= done_st;
        done_count  <= done_count + 1'b1;
      end
      // Chip output sampled on the rising ConfigClk
      if (state == SEQ_CONFIGOUT && rise_tick) cout_q <= config_out;
    end
  end

  // Queue level is filled in by the register block
  always_comb begin
    status             = '0;
    status.done_count  = done_count;
    status.config_out  = cout_q;
    status.busy        = busy;
    status.last_status = last_status;
  end

endmodule

/* source/config_reg_interface.sv */
module config_reg_interface (
  // Chip pins
  output logic               SuperpixSel,
  output logic               ConfigClk,
  output logic               Reset_not,
  output logic               ConfigIn,
  output logic               ConfigLoad,
  input  logic               ConfigOut,
  // AXI4-Lite slave
  input  logic               S_AXI_ACLK,
  input  logic               S_AXI_ARESETN,
  input  cfg_pkg::axi_addr_t S_AXI_AWADDR,
  input  logic [2:0]         S_AXI_AWPROT,
  input  logic               S_AXI_AWVALID,
  output logic               S_AXI_AWREADY,
  input  cfg_pkg::axi_data_t S_AXI_WDATA,
  input  logic [3:0]         S_AXI_WSTRB,
  input  logic               S_AXI_WVALID,
  output logic               S_AXI_WREADY,
  output logic [1:0]         S_AXI_BRESP,
  output logic               S_AXI_BVALID,
  input  logic               S_AXI_BREADY,
  input  cfg_pkg::axi_addr_t S_AXI_ARADDR,
  input  logic [2:0]         S_AXI_ARPROT,
  input  logic               S_AXI_ARVALID,
  output logic               S_AXI_ARREADY,
  output cfg_pkg::axi_data_t S_AXI_RDATA,
  output logic [1:0]         S_AXI_RRESP,
  output logic               S_AXI_RVALID,
  input  logic               S_AXI_RREADY
);
  import cfg_pkg::*;

  // Protection and byte strobes are accepted and ignored
  // Command words are always written whole

  logic        push;
  cfg_cmd_t    push_cmd;
  logic        pop;
  cfg_cmd_t    head_cmd;
  logic        fifo_empty;
  logic        fifo_full;
  fifo_cnt_t   fifo_level;
  logic        fall_tick;
  logic        rise_tick;
  cfg_status_t seq_status;

  // ----------------------------------------
  // AXI register block
  // ----------------------------------------
  axil_cfg_regs u_regs (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .S_AXI_AWADDR  (S_AXI_AWADDR),
    .S_AXI_AWVALID (S_AXI_AWVALID),
    .S_AXI_AWREADY (S_AXI_AWREADY),
    .S_AXI_WDATA   (S_AXI_WDATA),
    .S_AXI_WVALID  (S_AXI_WVALID),
    .S_AXI_WREADY  (S_AXI_WREADY),
    .S_AXI_BRESP   (S_AXI_BRESP),
    .S_AXI_BVALID  (S_AXI_BVALID),
    .S_AXI_BREADY  (S_AXI_BREADY),
    .S_AXI_ARADDR  (S_AXI_ARADDR),
    .S_AXI_ARVALID (S_AXI_ARVALID),
    .S_AXI_ARREADY (S_AXI_ARREADY),
    .S_AXI_RDATA   (S_AXI_RDATA),
    .S_AXI_RRESP   (S_AXI_RRESP),
    .S_AXI_RVALID  (S_AXI_RVALID),
    .S_AXI_RREADY  (S_AXI_RREADY),
    .push          (push),
    .push_cmd      (push_cmd),
    .fifo_full     (fifo_full),
    .fifo_level    (fifo_level),
    .status        (seq_status)
  );

  // Command queue between AXI and the sequencer
  cmd_fifo u_fifo (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .push          (push),
    .push_cmd      (push_cmd),
    .pop           (pop),
    .head_cmd      (head_cmd),
    .empty         (fifo_empty),
    .full          (fifo_full),
    .level         (fifo_level)
  );

  // Slow configuration clock and its edge ticks
  cfg_clk_gen u_clk_gen (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .config_clk    (ConfigClk),
    .fall_tick     (fall_tick),
    .rise_tick     (rise_tick)
  );

  // ----------------------------------------
  // Pin sequencer
  // ----------------------------------------
  cfg_sequencer u_seq (
    .S_AXI_ACLK    (S_AXI_ACLK),
    .S_AXI_ARESETN (S_AXI_ARESETN),
    .fall_tick     (fall_tick),
    .rise_tick     (rise_tick),
    .head_cmd      (head_cmd),
    .empty         (fifo_empty),
    .config_out    (ConfigOut),
    .pop           (pop),
    .superpix_sel  (SuperpixSel),
    .reset_n_pin   (Reset_not),
    .config_in     (ConfigIn),
    .config_load   (ConfigLoad),
    .status        (seq_status)
  );

endmodule

/* tests/cfg_chk.sv */
module cfg_chk (
  input logic clk,
  input logic rst_n,
  input logic reset_not,
  input logic config_in,
  input logic config_load,
  input logic pop,
  input logic empty,
  input logic bvalid,
  input logic bready,
  input logic rvalid,
  input logic rready
);
  timeunit 1ns;
  timeprecision 1ps;

  // Failure tally read back by the testbench
  int fails = 0;

  // At most one pin pulse active at a time
  a_pin_excl: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({~reset_not, config_in, config_load}))
    else begin
      $error("more than one chip pin pulse active");
      fails++;
    end

  // Responses stay up until taken
  a_b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else begin
      $error("BVALID dropped before BREADY");
      fails++;
    end

  a_r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid)
    else begin
      $error("RVALID dropped before RREADY");
      fails++;
    end

  a_no_pop_empty: assert property (@(posedge clk) disable iff (!rst_n)
    pop |-> !empty)
    else begin
      $error("pop from an empty command FIFO");
      fails++;
    end

endmodule

// ----------------------------------------
// Attach to sequencer, register block and command FIFO
// ----------------------------------------
bind cfg_sequencer cfg_chk seq_chk (
  .clk(S_AXI_ACLK), .rst_n(S_AXI_ARESETN), .reset_not(reset_n_pin),
  .config_in(config_in), .config_load(config_load), .pop(1'b0), .empty(1'b1),
  .bvalid(1'b0), .bready(1'b1), .rvalid(1'b0), .rready(1'b1)
);

bind axil_cfg_regs cfg_chk regs_chk (
  .clk(S_AXI_ACLK), .rst_n(S_AXI_ARESETN), .reset_not(1'b1),
  .config_in(1'b0), .config_load(1'b0), .pop(1'b0), .empty(1'b1),
  .bvalid(S_AXI_BVALID), .bready(S_AXI_BREADY),
  .rvalid(S_AXI_RVALID), .rready(S_AXI_RREADY)
);

// Pop strobe from the sequencer against the queue's own occupancy
bind cmd_fifo cfg_chk fifo_chk (
  .clk(S_AXI_ACLK), .rst_n(S_AXI_ARESETN), .reset_not(1'b1),
  .config_in(1'b0), .config_load(1'b0), .pop(pop), .empty(empty),
  .bvalid(1'b0), .bready(1'b1), .rvalid(1'b0), .rready(1'b1)
);

/* tests/cfg_monitor.sv */
module cfg_monitor (
  input logic              clk,
  input logic              rst_n,
  input logic              config_clk,
  input logic              config_in,
  input logic              config_load,
  input logic              reset_not,
  input logic              config_out,
  input logic              pop,
  input cfg_pkg::cfg_cmd_t head_cmd
);
  timeunit 1ns;
  timeprecision 1ps;
  import cfg_pkg::*;

  // Pin observations
  logic clk_q = 1'b0;
  logic load_q = 1'b0;
  logic rst_q = 1'b1;
  logic arm_in = 1'b0;
  logic arm_out = 1'b0;
  logic wait_arm = 1'b0;
  logic cout_prev = 1'b0;
  logic cout_seen = 1'b0;
  logic in_bits[$];
  int   rst_cnt = 0;
  int   rst_len = 0;
  int   load_pulses = 0;
  int   fall_cnt = 0;
  int   wait_falls = 0;
  // Bookkeeping
  string cur_test;
  int    test_err0 = 0;
  int    errors = 0;
  int    checks = 0;
  int    tests = 0;
  int    failed_tests = 0;

  // Sampled mid-cycle, away from the ACLK edge
  always @(negedge clk) begin
    if (rst_n) begin
      // Bit shifted by each CONFIGIN, taken at its rising ConfigClk
      if (pop && head_cmd.opcode == OP_CONFIGIN) arm_in = 1'b1;
      if (config_clk && !clk_q && arm_in) begin
        in_bits.push_back(config_in);
        arm_in = 1'b0;
      end
      // Chip output as it stood just before the rising edge
      if (pop && head_cmd.opcode == OP_CONFIGOUT) arm_out = 1'b1;
      if (config_clk && !clk_q && arm_out) begin
        cout_seen = cout_prev;
        arm_out   = 1'b0;
      end
      cout_prev = config_out;
      // Falling edges from WAIT start up to LOAD start
      if (pop && head_cmd.opcode == OP_LOAD && wait_arm) begin
        wait_falls = fall_cnt;
        wait_arm   = 1'b0;
      end
      if (!config_clk && clk_q && wait_arm) fall_cnt++;
      if (pop && head_cmd.opcode == OP_WAIT) begin
        wait_arm = 1'b1;
        fall_cnt = 0;
      end
      // Reset_not low time in ACLK cycles
      if (!reset_not) rst_cnt++;
      else if (!rst_q) begin
        rst_len = rst_cnt;
        rst_cnt = 0;
      end
      if (config_load && !load_q) load_pulses++;
    end
    clk_q  = config_clk;
    load_q = config_load;
    rst_q  = reset_not;
  end

  task automatic start_test(input string name);
    cur_test  = name;
    test_err0 = errors;
    tests++;
  endtask

  task automatic compare(input string what, input logic [31:0] exp_v,
                         input logic [31:0] act_v);
    checks++;
    if (exp_v !== act_v) begin
      errors++;
      $display("ERROR %s %s: expected %h, actual %h", cur_test, what, exp_v, act_v);
    end
  endtask

  task automatic end_test();
    if (errors == test_err0) $display("test %s: ok", cur_test);
    else begin
      failed_tests++;
      $display("test %s: failed with %0d errors", cur_test, errors - test_err0);
    end
  endtask

  task automatic report();
    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests, failed_tests, checks, errors);
  endtask

endmodule

/* tests/tb_config_reg.sv */
module tb_config_reg;
  timeunit 1ns;
  timeprecision 1ps;
  import cfg_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int SHORT_WAIT = 3;
  localparam int LONG_WAIT  = 40;
  localparam int NUM_CMDS   = 31;
  // Watchdog budget in ConfigClk periods
  localparam int WD_PERIODS = NUM_CMDS * 4 + (SHORT_WAIT + LONG_WAIT) + 64;

  logic S_AXI_ACLK = 1'b0;
  logic S_AXI_ARESETN;
  axi_addr_t S_AXI_AWADDR, S_AXI_ARADDR;
  axi_data_t S_AXI_WDATA, S_AXI_RDATA;
  logic [2:0] S_AXI_AWPROT, S_AXI_ARPROT;
  logic [3:0] S_AXI_WSTRB;
  logic S_AXI_AWVALID, S_AXI_AWREADY, S_AXI_WVALID, S_AXI_WREADY;
  logic [1:0] S_AXI_BRESP, S_AXI_RRESP;
  logic S_AXI_BVALID, S_AXI_BREADY, S_AXI_ARVALID, S_AXI_ARREADY;
  logic S_AXI_RVALID, S_AXI_RREADY;
  logic SuperpixSel, ConfigClk, Reset_not, ConfigIn, ConfigLoad, ConfigOut;
  // Chip shift register model
  logic [7:0] chip_sr = '0;
  logic [1:0] resp;
  axi_data_t  rd;
  logic       bits[8];
  int         ndone = 0;
  int         load0;
  int         chk_fails;

  config_reg_interface UUT (.*);

  cfg_monitor mon (
    .clk(S_AXI_ACLK), .rst_n(S_AXI_ARESETN), .config_clk(ConfigClk),
    .config_in(ConfigIn), .config_load(ConfigLoad), .reset_not(Reset_not),
    .config_out(ConfigOut), .pop(UUT.pop), .head_cmd(UUT.head_cmd)
  );

  always @(posedge ConfigClk or negedge Reset_not) begin
    if (!Reset_not) chip_sr <= '0;
    else chip_sr <= {chip_sr[6:0], ConfigIn};
  end
  assign ConfigOut = chip_sr[7];

  initial begin
    forever #(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;
  end

  initial begin
    #(WD_PERIODS * 2 * CFG_CLK_DIV * CLK_PERIOD);
    $display("Timeout: the commands did not finish within the expected time");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  // Expected status word built from the register layout
  function automatic axi_data_t exp_status(input int done, input status_t st, input logic cout);
    return {8'(done), 8'h00, 7'h00, cout, 3'b000, 1'b0, st};
  endfunction

  function automatic axi_data_t cmd_word(input opcode_t op, input logic sp, input logic b,
                                         input int wl);
    return {16'(wl), 10'h000, b, sp, op};
  endfunction

  task automatic next_cycle();
    @(posedge S_AXI_ACLK);
    #10;
  endtask

  task automatic axi_write(input axi_addr_t a, input axi_data_t d, output logic [1:0] r);
    S_AXI_AWADDR  = a;
    S_AXI_WDATA   = d;
    S_AXI_AWVALID = 1'b1;
    S_AXI_WVALID  = 1'b1;
    while (!(S_AXI_AWREADY && S_AXI_WREADY)) next_cycle();
    next_cycle();
    S_AXI_AWVALID = 1'b0;
    S_AXI_WVALID  = 1'b0;
    while (!S_AXI_BVALID) next_cycle();
    r = S_AXI_BRESP;
    // Response left waiting one cycle before it is taken
    next_cycle();
    S_AXI_BREADY = 1'b1;
    next_cycle();
    S_AXI_BREADY = 1'b0;
  endtask

  task automatic axi_read(input axi_addr_t a, output axi_data_t d, output logic [1:0] r);
    S_AXI_ARADDR  = a;
    S_AXI_ARVALID = 1'b1;
    while (!S_AXI_ARREADY) next_cycle();
    next_cycle();
    S_AXI_ARVALID = 1'b0;
    while (!S_AXI_RVALID) next_cycle();
    d = S_AXI_RDATA;
    r = S_AXI_RRESP;
    // Read data left waiting one cycle before it is taken
    next_cycle();
    S_AXI_RREADY = 1'b1;
    next_cycle();
    S_AXI_RREADY = 1'b0;
  endtask

  task automatic send_cmd(input axi_data_t w);
    logic [1:0] r;
    axi_write(ADDR_CMD, w, r);
    mon.compare("bresp", 32'(RESP_OKAY), 32'(r));
  endtask

  // Poll the status until done_count reaches n
  task automatic read_until_count(input int n, output axi_data_t d);
    logic [1:0] r;
    d = '0;
    axi_read(ADDR_STATUS, d, r);
    while (d[31:24] != 8'(n)) axi_read(ADDR_STATUS, d, r);
  endtask

  initial begin
    S_AXI_ARESETN = 1'b0;
    {S_AXI_AWADDR, S_AXI_ARADDR, S_AXI_WDATA} = '0;
    {S_AXI_AWPROT, S_AXI_ARPROT, S_AXI_WSTRB} = '0;
    {S_AXI_AWVALID, S_AXI_WVALID, S_AXI_ARVALID} = '0;
    S_AXI_BREADY = 1'b0;
    S_AXI_RREADY = 1'b0;
    void'($urandom(32'h873717a4));
    repeat (4) @(posedge S_AXI_ACLK);
    #10;
    S_AXI_ARESETN = 1'b1;

    mon.start_test("reset_values");
    mon.compare("pins", 32'b0010000000,
                32'({SuperpixSel, ConfigClk, Reset_not, ConfigIn, ConfigLoad,
                     S_AXI_AWREADY, S_AXI_WREADY, S_AXI_BVALID,
                     S_AXI_ARREADY, S_AXI_RVALID}));
    axi_read(ADDR_STATUS, rd, resp);
    mon.compare("status", 32'h0, rd);
    mon.compare("rresp", 32'(RESP_OKAY), 32'(resp));
    mon.end_test();

    mon.start_test("reset_cmd");
    for (int sp = 1; sp >= 0; sp--) begin
      mon.rst_len = 0;
      send_cmd(cmd_word(OP_RESET, 1'(sp), 1'b0, 0));
      ndone++;
      read_until_count(ndone, rd);
      mon.compare("status", exp_status(ndone, ST_RESET, 1'b0), rd);
      mon.compare("superpix", 32'(sp), 32'(SuperpixSel));
      mon.compare("reset_len", 32'(2 * CFG_CLK_DIV), 32'(mon.rst_len));
    end
    mon.end_test();

    // Eight random bits, a load and a readback, all queued together
    mon.start_test("config_shift");
    mon.in_bits.delete();
    load0 = mon.load_pulses;
    for (int i = 0; i < 8; i++) begin
      bits[i] = 1'($urandom);
      send_cmd(cmd_word(OP_CONFIGIN, 1'b0, bits[i], 0));
    end
    send_cmd(cmd_word(OP_LOAD, 1'b0, 1'b0, 0));
    send_cmd(cmd_word(OP_CONFIGOUT, 1'b0, 1'b0, 0));
    ndone += 10;
    read_until_count(ndone, rd);
    mon.compare("bit_count", 32'd8, 32'(mon.in_bits.size()));
    for (int i = 0; i < 8 && i < mon.in_bits.size(); i++)
      mon.compare($sformatf("bit%0d", i), 32'(bits[i]), 32'(mon.in_bits[i]));
    mon.compare("load_pulses", 32'd1, 32'(mon.load_pulses - load0));
    mon.end_test();

    mon.start_test("config_out");
    mon.compare("status", exp_status(ndone, ST_CONFIGOUT, mon.cout_seen), rd);
    mon.end_test();

    mon.start_test("wait_load");
    send_cmd(cmd_word(OP_WAIT, 1'b0, 1'b0, SHORT_WAIT));
    send_cmd(cmd_word(OP_LOAD, 1'b0, 1'b0, 0));
    read_until_count(ndone + 1, rd);
    mon.compare("wait_status", 32'(ST_WAIT), 32'(rd[3:0]));
    ndone += 2;
    read_until_count(ndone, rd);
    mon.compare("status", exp_status(ndone, ST_LOAD, mon.cout_seen), rd);
    mon.compare("fall_edges", 32'(SHORT_WAIT + 1), 32'(mon.wait_falls));
    mon.end_test();

    // Fill the queue behind a long WAIT
    mon.start_test("errors");
    send_cmd(cmd_word(OP_WAIT, 1'b0, 1'b0, LONG_WAIT));
    axi_read(ADDR_STATUS, rd, resp);
    while (!rd[4]) axi_read(ADDR_STATUS, rd, resp);
    for (int i = 0; i < CMD_FIFO_DEPTH; i++) send_cmd(cmd_word(4'hF, 1'b0, 1'b0, 0));
    axi_write(ADDR_CMD, cmd_word(4'hF, 1'b0, 1'b0, 0), resp);
    mon.compare("full_bresp", 32'(RESP_SLVERR), 32'(resp));
    axi_read(ADDR_STATUS, rd, resp);
    mon.compare("fifo_level", 32'(CMD_FIFO_DEPTH), 32'(rd[23:16]));
    axi_read(11'h008, rd, resp);
    mon.compare("unmapped_rresp", 32'(RESP_SLVERR), 32'(resp));
    mon.compare("unmapped_data", 32'h0, rd);
    ndone += 1 + CMD_FIFO_DEPTH;
    read_until_count(ndone, rd);
    mon.compare("status", exp_status(ndone, ST_IDLE, mon.cout_seen), rd);
    mon.end_test();

    mon.report();
    chk_fails = UUT.u_seq.seq_chk.fails + UUT.u_regs.regs_chk.fails
              + UUT.u_fifo.fifo_chk.fails;
    if (chk_fails != 0) $display("%0d assertion failures were seen", chk_fails);
    if (mon.errors == 0 && chk_fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
source/cfg_pkg.sv
source/axil_cfg_regs.sv
source/cmd_fifo.sv
source/cfg_clk_gen.sv
source/cfg_sequencer.sv
source/config_reg_interface.sv
tests/cfg_chk.sv
tests/cfg_monitor.sv
tests/tb_config_reg.sv

/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --timing --assert -Wno-fatal
TOP       = tb_config_reg
FILELIST  = all.f
OBJ_DIR   = obj_dir
LOG       = sim.log
SIM       = $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(SIM) +verilator+error+limit+1000 | tee $(LOG)
	grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
